// ==== design/cr_pkg.sv ====
//============================
// Control-register map, reset values and shared types
// Byte addresses, one 32-bit word per register
// Unmapped addresses read as zero and drop writes
// Per-thread registers sit at base + 4*i
//============================
`default_nettype none

package cr_pkg;

    localparam int cr_addr_w   = 12;
    localparam int cr_data_w   = 32;
    localparam int num_threads = 4;
    localparam int num_scratch = 4;
    localparam int thread_id_w = $clog2(num_threads);

    //============================
    // Address map
    //============================
    localparam logic [cr_addr_w-1:0] cr_who_am_i           = 12'h000;
    localparam logic [cr_addr_w-1:0] cr_thread_id          = 12'h004;
    localparam logic [cr_addr_w-1:0] cr_core_id            = 12'h008;
    localparam logic [cr_addr_w-1:0] cr_stack_base_offset  = 12'h00C; // Current thread
    localparam logic [cr_addr_w-1:0] cr_tls_base_offset    = 12'h010; // Current thread
    localparam logic [cr_addr_w-1:0] cr_shared_base_offset = 12'h014;
    localparam logic [cr_addr_w-1:0] cr_i_mem_msb          = 12'h018;
    localparam logic [cr_addr_w-1:0] cr_d_mem_msb          = 12'h01C;
    localparam logic [cr_addr_w-1:0] cr_thread_pc_rst_base = 12'h040;
    localparam logic [cr_addr_w-1:0] cr_thread_pc_en_base  = 12'h050;
    localparam logic [cr_addr_w-1:0] cr_thread_stack_base  = 12'h060;
    localparam logic [cr_addr_w-1:0] cr_thread_tls_base    = 12'h070;
    localparam logic [cr_addr_w-1:0] cr_thread_pc_base     = 12'h080; // Read only
    localparam logic [cr_addr_w-1:0] cr_scratchpad_base    = 12'h090;

    //============================
    // Reset values
    //============================
    localparam logic [cr_data_w-1:0] stk_rst_base = 32'h0040_0200;
    localparam logic [cr_data_w-1:0] stk_rst_step = 32'h0000_0200; // Spacing between threads
    localparam logic [cr_data_w-1:0] shrd_rst_val = 32'h0040_0f00;

    typedef struct packed {
        logic [cr_addr_w-1:0] addr;
        logic [cr_data_w-1:0] wr_data;
        logic                 rd_en;
        logic                 wr_en;
    } t_cr_req;

    // One bit per software-writable register
    typedef struct packed {
        logic [num_threads-1:0] rst_pc;
        logic [num_threads-1:0] en_pc;
        logic [num_threads-1:0] stk_ofst;
        logic [num_threads-1:0] tls_ofst;
        logic [num_scratch-1:0] scratch_pad;
        logic                   shrd_ofst;
    } t_cr_wr_en;

    typedef struct packed {
        logic [num_threads-1:0] rst_pc; // Hold thread pc at reset
        logic [num_threads-1:0] en_pc;  // Thread allowed to fetch
    } t_core_cr;

    typedef struct packed {
        t_core_cr                                 ctrl;
        logic [num_threads-1:0][cr_data_w-1:0]    stk_ofst;
        logic [num_threads-1:0][cr_data_w-1:0]    tls_ofst;
        logic [cr_data_w-1:0]                     shrd_ofst;
        logic [num_scratch-1:0][cr_data_w-1:0]    scratch_pad;
    } t_cr_rw;

    typedef struct packed {
        logic [thread_id_w-1:0]                   thread;
        logic [cr_data_w-1:0]                     stk_ofst;
        logic [cr_data_w-1:0]                     tls_ofst;
        logic [num_threads-1:0][cr_data_w-1:0]    pc;
    } t_cr_hw;

    function automatic logic [cr_addr_w-1:0] thread_addr(input logic [cr_addr_w-1:0] base,
                                                         input int idx);
        return base + cr_addr_w'(4 * idx);
    endfunction

    function automatic logic [cr_data_w-1:0] ofst_rst_val(input int idx);
        return stk_rst_base + stk_rst_step * cr_data_w'(idx);
    endfunction

endpackage

`default_nettype wire

// ==== design/cr_write_arbiter.sv ====
//============================
// Write decode for the core and ring ports
// Only writable addresses produce an enable
// Ring port wins when both hit one register
//============================
`timescale 1ns/10ps
`default_nettype none

module cr_write_arbiter (
    input  wire cr_pkg::t_cr_req    core_req,
    input  wire cr_pkg::t_cr_req    ring_req,
    output cr_pkg::t_cr_wr_en       wr_en,
    output cr_pkg::t_cr_wr_en       ring_sel
);
    import cr_pkg::*;

    t_cr_wr_en core_en;
    t_cr_wr_en ring_en;

    function automatic t_cr_wr_en decode_wr(input t_cr_req req);
        t_cr_wr_en en;
        en = '0;
        if (req.wr_en) begin
            if (req.addr == cr_shared_base_offset) begin
                en.shrd_ofst = 1'b1;
            end
            for (int i = 0; i < num_threads; i++) begin
                if (req.addr == thread_addr(cr_thread_pc_rst_base, i)) en.rst_pc[i] = 1'b1;
                if (req.addr == thread_addr(cr_thread_pc_en_base, i))  en.en_pc[i] = 1'b1;
                if (req.addr == thread_addr(cr_thread_stack_base, i))  en.stk_ofst[i] = 1'b1;
                if (req.addr == thread_addr(cr_thread_tls_base, i))    en.tls_ofst[i] = 1'b1;
            end
            for (int i = 0; i < num_scratch; i++) begin
                if (req.addr == thread_addr(cr_scratchpad_base, i)) en.scratch_pad[i] = 1'b1;
            end
        end
        return en;
    endfunction

    //============================
    // Per-port decode
    //============================
    always_comb begin
        core_en = decode_wr(core_req);
        ring_en = decode_wr(ring_req);
    end

    //============================
    // Merge
    //============================
    assign wr_en    = core_en | ring_en; // Either port loads the register
    assign ring_sel = ring_en;           // Ring data taken wherever ring writes

endmodule

`default_nettype wire

// ==== design/cr_rw_regs.sv ====
//============================
// Software-writable control registers
// Loads from the port named by ring_sel
// Single-bit registers take data bit 0
//============================
`timescale 1ns/10ps
`default_nettype none

module cr_rw_regs (
    input  wire                             qclk,
    input  wire                             reset,
    input  wire cr_pkg::t_cr_wr_en          wr_en,
    input  wire cr_pkg::t_cr_wr_en          ring_sel,
    input  wire [cr_pkg::cr_data_w-1:0]     core_wr_data,
    input  wire [cr_pkg::cr_data_w-1:0]     ring_wr_data,
    output cr_pkg::t_cr_rw                  rw,
    output cr_pkg::t_core_cr                core_cr
);
    import cr_pkg::*;

    function automatic logic [cr_data_w-1:0] wr_word(input logic from_ring);
        return from_ring ? ring_wr_data : core_wr_data;
    endfunction

    function automatic logic wr_bit(input logic from_ring);
        return from_ring ? ring_wr_data[0] : core_wr_data[0];
    endfunction

    always_ff @(posedge qclk) begin
        if (reset) begin
            rw.ctrl.rst_pc <= '0;            // No thread held
            rw.ctrl.en_pc  <= '1;            // Every thread runs
            rw.shrd_ofst   <= shrd_rst_val;
            rw.scratch_pad <= '0;
            for (int i = 0; i < num_threads; i++) begin
                rw.stk_ofst[i] <= ofst_rst_val(i);
                rw.tls_ofst[i] <= ofst_rst_val(i); // Same layout as the stack
            end
        end else begin
            for (int i = 0; i < num_threads; i++) begin
                if (wr_en.rst_pc[i]) begin
                    rw.ctrl.rst_pc[i] <= wr_bit(ring_sel.rst_pc[i]);
                end
                if (wr_en.en_pc[i]) begin
                    rw.ctrl.en_pc[i] <= wr_bit(ring_sel.en_pc[i]);
                end
                if (wr_en.stk_ofst[i]) begin
                    rw.stk_ofst[i] <= wr_word(ring_sel.stk_ofst[i]);
                end
                if (wr_en.tls_ofst[i]) begin
                    rw.tls_ofst[i] <= wr_word(ring_sel.tls_ofst[i]);
                end
            end
            for (int i = 0; i < num_scratch; i++) begin
                if (wr_en.scratch_pad[i]) begin
                    rw.scratch_pad[i] <= wr_word(ring_sel.scratch_pad[i]);
                end
            end
            if (wr_en.shrd_ofst) begin
                rw.shrd_ofst <= wr_word(ring_sel.shrd_ofst);
            end
        end
    end

    assign core_cr = rw.ctrl; // Run control straight from the flops

endmodule

`default_nettype wire

// ==== design/cr_thread_capture.sv ====
//============================
// Thread tracking from the pipeline
// thread_vec is expected one-hot, anything else maps to thread 3
// Captured values appear one cycle later
//============================
`timescale 1ns/10ps
`default_nettype none

module cr_thread_capture (
    input  wire                             qclk,
    input  wire                             reset,
    input  wire [cr_pkg::num_threads-1:0]   thread_vec,
    input  wire [cr_pkg::cr_data_w-1:0]     pc,
    input  wire cr_pkg::t_cr_rw             rw,
    output cr_pkg::t_cr_hw                  hw
);
    import cr_pkg::*;

    logic [num_threads-1:0] thread_rot;
    logic [thread_id_w-1:0] thread_id;

    //============================
    // Thread decode
    //============================
    // Pipeline vector leads the CR stage by one thread
    assign thread_rot = {thread_vec[num_threads-2:0], thread_vec[num_threads-1]};

    always_comb begin
        thread_id = thread_id_w'(num_threads - 1);     // Fallback for bad vectors
        for (int i = 0; i < num_threads - 1; i++) begin
            if (thread_rot == (num_threads'(1) << i)) begin
                thread_id = thread_id_w'(i);
            end
        end
    end

    //============================
    // Capture
    //============================
    always_ff @(posedge qclk) begin
        if (reset) begin
            hw <= '0;
        end else begin
            hw.thread        <= thread_id;
            hw.stk_ofst      <= rw.stk_ofst[thread_id];
            hw.tls_ofst      <= rw.tls_ofst[thread_id];
            hw.pc[thread_id] <= pc;                    // Other threads keep their pc
        end
    end

endmodule

`default_nettype wire

// ==== design/cr_read_mux.sv ====
//============================
// Read decode for one port
// Data is registered, valid the cycle after the request
// No read enable or unmapped address gives zero
//============================
`timescale 1ns/10ps
`default_nettype none

module cr_read_mux #(
    parameter logic [7:0] i_mem_msb = 8'h0F,
    parameter logic [7:0] d_mem_msb = 8'h0D
) (
    input  wire                             qclk,
    input  wire                             reset,
    input  wire cr_pkg::t_cr_req            req,
    input  wire cr_pkg::t_cr_rw             rw,
    input  wire cr_pkg::t_cr_hw             hw,
    input  wire [7:0]                       core_id_strap,
    output logic [cr_pkg::cr_data_w-1:0]    rd_data
);
    import cr_pkg::*;

    logic [cr_data_w-1:0] rd_next;

    //============================
    // Address decode
    //============================
    always_comb begin
        rd_next = '0;
        if (req.rd_en) begin
            case (req.addr)
                cr_who_am_i:           rd_next = {22'b0, core_id_strap, hw.thread};
                cr_thread_id:          rd_next = cr_data_w'(hw.thread);
                cr_core_id:            rd_next = cr_data_w'(core_id_strap);
                cr_stack_base_offset:  rd_next = hw.stk_ofst;
                cr_tls_base_offset:    rd_next = hw.tls_ofst;
                cr_shared_base_offset: rd_next = rw.shrd_ofst;
                cr_i_mem_msb:          rd_next = cr_data_w'(i_mem_msb);
                cr_d_mem_msb:          rd_next = cr_data_w'(d_mem_msb);
                default:               rd_next = '0;
            endcase
            // Per-thread blocks
            for (int i = 0; i < num_threads; i++) begin
                if (req.addr == thread_addr(cr_thread_pc_rst_base, i)) begin
                    rd_next = cr_data_w'(rw.ctrl.rst_pc[i]);
                end
                if (req.addr == thread_addr(cr_thread_pc_en_base, i)) begin
                    rd_next = cr_data_w'(rw.ctrl.en_pc[i]);
                end
                if (req.addr == thread_addr(cr_thread_stack_base, i)) begin
                    rd_next = rw.stk_ofst[i];
                end
                if (req.addr == thread_addr(cr_thread_tls_base, i)) begin
                    rd_next = rw.tls_ofst[i];
                end
                if (req.addr == thread_addr(cr_thread_pc_base, i)) begin
                    rd_next = hw.pc[i];
                end
            end
            for (int i = 0; i < num_scratch; i++) begin
                if (req.addr == thread_addr(cr_scratchpad_base, i)) begin
                    rd_next = rw.scratch_pad[i];
                end
            end
        end
    end

    // Sampled read, sees register state from before this cycle's writes
    always_ff @(posedge qclk) begin
        if (reset) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/cr_mem.sv ====
//============================
// Control-register block for a four-thread core
// Core and ring ports, both accepted every cycle
// Ring port wins on a same-register write
//============================
`timescale 1ns/10ps
`default_nettype none

module cr_mem #(
    parameter logic [7:0] i_mem_msb = 8'h0F,
    parameter logic [7:0] d_mem_msb = 8'h0D
) (
    input  wire                             qclk,
    input  wire                             reset,
    input  wire [7:0]                       core_id_strap,
    input  wire cr_pkg::t_cr_req            core_req,
    input  wire cr_pkg::t_cr_req            ring_req,
    input  wire [cr_pkg::num_threads-1:0]   thread_vec,
    input  wire [cr_pkg::cr_data_w-1:0]     pc,
    output logic [cr_pkg::cr_data_w-1:0]    core_rd_data,
    output logic [cr_pkg::cr_data_w-1:0]    ring_rd_data,
    output cr_pkg::t_core_cr                core_cr
);
    import cr_pkg::*;

    t_cr_wr_en wr_en;
    t_cr_wr_en ring_sel;
    t_cr_rw    rw;
    t_cr_hw    hw;

    //============================
    // Write path
    //============================
    cr_write_arbiter cr_write_arbiter_inst (.core_req(core_req), .ring_req(ring_req),
                                            .wr_en(wr_en), .ring_sel(ring_sel));

    cr_rw_regs cr_rw_regs_inst (.qclk(qclk), .reset(reset), .wr_en(wr_en),
                                .ring_sel(ring_sel), .core_wr_data(core_req.wr_data),
                                .ring_wr_data(ring_req.wr_data), .rw(rw), .core_cr(core_cr));

    cr_thread_capture cr_thread_capture_inst (.qclk(qclk), .reset(reset),
                                              .thread_vec(thread_vec), .pc(pc),
                                              .rw(rw), .hw(hw));

    //============================
    // Read path, one mux per port
    //============================
    cr_read_mux #(.i_mem_msb(i_mem_msb), .d_mem_msb(d_mem_msb)) core_read_mux (
        .qclk(qclk), .reset(reset), .req(core_req), .rw(rw), .hw(hw),
        .core_id_strap(core_id_strap), .rd_data(core_rd_data));

    cr_read_mux #(.i_mem_msb(i_mem_msb), .d_mem_msb(d_mem_msb)) ring_read_mux (
        .qclk(qclk), .reset(reset), .req(ring_req), .rw(rw), .hw(hw),
        .core_id_strap(core_id_strap), .rd_data(ring_rd_data));

endmodule

`default_nettype wire

// ==== tb/tb_cr_mem.sv ====
//============================
// Random and directed testbench for cr_mem
// Model predicts read data one cycle late
// core_cr is compared after every clock
// Stops at the first mismatch
//============================
`timescale 1ns/10ps
`default_nettype none

module tb_cr_mem;
    import cr_pkg::*;

    localparam logic [7:0] i_mem_val    = 8'h1E;
    localparam logic [7:0] d_mem_val    = 8'h0B;
    localparam int         reset_cycles = 8;
    localparam int         rand_cycles  = 600;
    localparam int         total_cycles = reset_cycles + 32 + rand_cycles + 64 + 48 + 40 + 32;
    localparam int         watchdog_ns  = total_cycles * 20 + 2000; // Margin for idle cycles

    logic                 qclk;
    logic                 reset;
    logic [7:0]           core_id_strap;
    t_cr_req              core_req;
    t_cr_req              ring_req;
    logic [3:0]           thread_vec;
    logic [cr_data_w-1:0] pc;
    logic [cr_data_w-1:0] core_rd_data;
    logic [cr_data_w-1:0] ring_rd_data;
    t_core_cr             core_cr;

    logic [31:0]          lcg_state;
    int                   rot_idx;

    // Model state
    logic [3:0]           m_rst_pc;
    logic [3:0]           m_en_pc;
    logic [31:0]          m_stk [4];
    logic [31:0]          m_tls [4];
    logic [31:0]          m_scr [4];
    logic [31:0]          m_pc [4];
    logic [31:0]          m_shrd;
    logic [31:0]          m_cur_stk;
    logic [31:0]          m_cur_tls;
    logic [1:0]           m_thread;

    cr_mem #(.i_mem_msb(i_mem_val), .d_mem_msb(d_mem_val)) cr_mem_inst (
        .qclk(qclk), .reset(reset), .core_id_strap(core_id_strap), .core_req(core_req),
        .ring_req(ring_req), .thread_vec(thread_vec), .pc(pc), .core_rd_data(core_rd_data),
        .ring_rd_data(ring_rd_data), .core_cr(core_cr));

    always #10 qclk = ~qclk; // 20 ns period

    //============================
    // Stimulus helpers
    //============================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Mapped words are 0x000-0x01C and 0x040-0x09C
    function automatic logic [11:0] mapped_addr(input int k);
        return (k < 8) ? 12'(4 * k) : 12'(12'h040 + 4 * (k - 8));
    endfunction

    function automatic t_cr_req make_req(input logic [11:0] addr, input logic [31:0] data,
                                         input logic rd, input logic wr);
        t_cr_req req;
        req.addr    = addr;
        req.wr_data = data;
        req.rd_en   = rd;
        req.wr_en   = wr;
        return req;
    endfunction

    function automatic t_cr_req random_req();
        logic [31:0] r;
        logic [31:0] u;
        logic [11:0] addr;
        r = lcg_next();
        u = lcg_next();
        addr = (r[31:28] < 4'd12) ? mapped_addr(int'(r[27:23])) : u[27:16]; // Mostly mapped
        return make_req(addr, lcg_next(), r[20], r[21]);
    endfunction

    function automatic logic [3:0] next_thread_vec();
        logic [31:0] r;
        r = lcg_next();
        rot_idx = (rot_idx + 1) % 4;
        if (r[31:29] == 3'd0) begin
            return r[19:16]; // Occasional bad vector
        end
        return 4'b0001 << rot_idx;
    endfunction

    //============================
    // Model
    //============================
    task automatic reset_model();
        m_rst_pc  = 4'h0;
        m_en_pc   = 4'hF;
        m_shrd    = 32'h0040_0f00;
        m_cur_stk = '0;
        m_cur_tls = '0;
        m_thread  = '0;
        for (int i = 0; i < 4; i++) begin
            m_stk[i] = 32'h0040_0200 + 32'h200 * i;
            m_tls[i] = 32'h0040_0200 + 32'h200 * i;
            m_scr[i] = '0;
            m_pc[i]  = '0;
        end
    endtask

    function automatic logic [31:0] expected_read(input t_cr_req req);
        logic [31:0] d;
        d = '0;
        if (req.rd_en) begin
            case (req.addr)
                12'h000: d = {22'b0, core_id_strap, m_thread};
                12'h004: d = {30'b0, m_thread};
                12'h008: d = {24'b0, core_id_strap};
                12'h00C: d = m_cur_stk;
                12'h010: d = m_cur_tls;
                12'h014: d = m_shrd;
                12'h018: d = {24'b0, i_mem_val};
                12'h01C: d = {24'b0, d_mem_val};
                default: d = '0;
            endcase
            for (int i = 0; i < 4; i++) begin
                if (req.addr == 12'(12'h040 + 4 * i)) d = {31'b0, m_rst_pc[i]};
                if (req.addr == 12'(12'h050 + 4 * i)) d = {31'b0, m_en_pc[i]};
                if (req.addr == 12'(12'h060 + 4 * i)) d = m_stk[i];
                if (req.addr == 12'(12'h070 + 4 * i)) d = m_tls[i];
                if (req.addr == 12'(12'h080 + 4 * i)) d = m_pc[i];
                if (req.addr == 12'(12'h090 + 4 * i)) d = m_scr[i];
            end
        end
        return d;
    endfunction

    // Thread id is one past the set bit, bad vectors give 3
    task automatic capture_thread(input logic [3:0] vec, input logic [31:0] pc_val);
        logic [1:0] id;
        case (vec)
            4'b0001: id = 2'd1;
            4'b0010: id = 2'd2;
            4'b0100: id = 2'd3;
            4'b1000: id = 2'd0;
            default: id = 2'd3;
        endcase
        m_thread  = id;
        m_cur_stk = m_stk[id];
        m_cur_tls = m_tls[id];
        m_pc[id]  = pc_val;
    endtask

    task automatic write_model_reg(input t_cr_req req);
        if (req.wr_en) begin
            if (req.addr == 12'h014) m_shrd = req.wr_data;
            for (int i = 0; i < 4; i++) begin
                if (req.addr == 12'(12'h040 + 4 * i)) m_rst_pc[i] = req.wr_data[0];
                if (req.addr == 12'(12'h050 + 4 * i)) m_en_pc[i] = req.wr_data[0];
                if (req.addr == 12'(12'h060 + 4 * i)) m_stk[i] = req.wr_data;
                if (req.addr == 12'(12'h070 + 4 * i)) m_tls[i] = req.wr_data;
                if (req.addr == 12'(12'h090 + 4 * i)) m_scr[i] = req.wr_data;
            end
        end
    endtask

    function automatic t_core_cr model_core_cr();
        t_core_cr c;
        c.rst_pc = m_rst_pc;
        c.en_pc  = m_en_pc;
        return c;
    endfunction

    //============================
    // Checks
    //============================
    task automatic check_rd_data(input string port, input logic [cr_data_w-1:0] got,
                                 input logic [cr_data_w-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s read data %h, expected %h", $time, port, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Read data mismatch");
        end
    endtask

    task automatic check_core_cr(input t_core_cr got, input t_core_cr exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: core_cr %b, expected %b", $time, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "core_cr mismatch");
        end
    endtask

    // Inputs are already driven, one clock then compare
    task automatic run_cycle();
        logic [31:0] exp_core;
        logic [31:0] exp_ring;
        exp_core = expected_read(core_req); // Reads see state before this edge
        exp_ring = expected_read(ring_req);
        capture_thread(thread_vec, pc);
        write_model_reg(core_req);
        write_model_reg(ring_req);          // Ring last so it wins
        @(posedge qclk);
        #1;
        check_rd_data("core", core_rd_data, exp_core);
        check_rd_data("ring", ring_rd_data, exp_ring);
        check_core_cr(core_cr, model_core_cr());
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired, the simulation did not finish in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    end

    //============================
    // Test sequence
    //============================
    initial begin
        qclk          = 1'b0;
        reset         = 1'b1;
        core_id_strap = 8'hA5;
        core_req      = '0;
        ring_req      = '0;
        thread_vec    = '0;
        pc            = '0;
        rot_idx       = 0;
        lcg_state     = 32'h2d0e;
        reset_model();
        repeat (reset_cycles) @(posedge qclk);
        #1;
        reset = 1'b0;
        check_rd_data("core", core_rd_data, '0);
        check_rd_data("ring", ring_rd_data, '0);
        check_core_cr(core_cr, model_core_cr());

        for (int k = 0; k < 32; k++) begin  // Reset values on every mapped word
            core_req = make_req(mapped_addr(k), '0, 1'b1, 1'b0);
            ring_req = make_req(mapped_addr(31 - k), '0, 1'b1, 1'b0);
            run_cycle();
        end

        for (int c = 0; c < rand_cycles; c++) begin
            core_req   = random_req();
            ring_req   = random_req();
            thread_vec = next_thread_vec();
            pc         = lcg_next();
            run_cycle();
        end

        for (int k = 0; k < 32; k++) begin  // Same-register collisions, then read back
            core_req = make_req(mapped_addr(k), lcg_next(), 1'b0, 1'b1);
            ring_req = make_req(mapped_addr(k), lcg_next(), 1'b0, 1'b1);
            run_cycle();
            core_req = make_req(mapped_addr(k), '0, 1'b1, 1'b0);
            ring_req = make_req(mapped_addr(k), '0, 1'b1, 1'b0);
            run_cycle();
        end

        for (int c = 0; c < 48; c++) begin  // Clean rotation with thread reads
            thread_vec = 4'b0001 << (c % 4);
            pc         = lcg_next();
            core_req   = make_req(12'(4 * ((c / 4) % 5)), '0, 1'b1, 1'b0);
            ring_req   = make_req(12'(12'h080 + 4 * (c % 4)), '0, 1'b1, 1'b0);
            run_cycle();
        end

        for (int c = 0; c < 40; c++) begin  // Run-control writes
            core_req = make_req(12'(12'h040 + 4 * (c % 8)), lcg_next(), 1'b1, 1'b1);
            ring_req = make_req(12'(12'h040 + 4 * ((c + 3) % 8)), lcg_next(), 1'b1, c[0]);
            run_cycle();
        end

        for (int c = 0; c < 32; c++) begin  // Read-only words ignore writes
            core_id_strap = 8'(lcg_next() >> 24);
            core_req = make_req((c % 16 < 8) ? 12'(4 * (c % 8)) : 12'(12'h080 + 4 * (c % 4)),
                                lcg_next(), 1'b0, 1'b1);
            ring_req = make_req(12'(4 * ((c + 1) % 8)), '0, 1'b1, 1'b0);
            run_cycle();
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/cr_pkg.sv
design/cr_write_arbiter.sv
design/cr_rw_regs.sv
design/cr_thread_capture.sv
design/cr_read_mux.sv
design/cr_mem.sv
tb/tb_cr_mem.sv
